//--- devtbl.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module devtbl (
	input  logic                    clk100mhz_i,
	input  logic                    sys_rst_i,
	input  logic                    dec_valid_i,
	input  soc_bus_pkg::slave_idx_e dec_slave_i,
	input  soc_bus_pkg::pi1_op_e    dec_op_i,
	input  soc_bus_pkg::pi1_addr_t  dec_offset_i,
	input  soc_bus_pkg::pi1_data_t  dec_data_i,
	output soc_bus_pkg::pi1_data_t  rd_data_o,
	output soc_dev_pkg::rst_req_e   rst_bits_o
);

	localparam int SLVCNT = int'(soc_bus_pkg::SLV_INVALID) + 1;
	localparam int FLDCNT = int'(soc_dev_pkg::FLD_USEINTR) + 1;

	localparam soc_bus_pkg::pi1_addr_t RSTREG_OFS =
		soc_bus_pkg::pi1_addr_t'(`DEVTBL_RSTREG_IDX);

	// Per slave constants, in slave index order.
	localparam soc_bus_pkg::pi1_data_t DEV_ID [SLVCNT] =
		'{`DEVID_DEVTBL, `DEVID_GPIO, `DEVID_INVALID};
	localparam soc_bus_pkg::pi1_data_t DEV_MAPSZ [SLVCNT] =
		'{`DEVTBL_MAPSZ, `GPIO_MAPSZ, `INVALIDDEV_MAPSZ};
	// No interrupt controller, so these are fixed.
	localparam soc_bus_pkg::pi1_data_t DEV_USEINTR [SLVCNT] =
		'{0, 1, 0};

	logic sel_hit;
	logic wr_en;
	soc_bus_pkg::pi1_addr_t ent;
	soc_bus_pkg::pi1_data_t tbl_word;
	soc_dev_pkg::rst_req_e rst_q;

	assign sel_hit = dec_valid_i && (dec_slave_i == soc_bus_pkg::SLV_DEVTBL);
	assign wr_en = sel_hit && ((dec_op_i == soc_bus_pkg::PI1_WR) ||
		(dec_op_i == soc_bus_pkg::PI1_RDWR));

	// Word FLDCNT*i+field describes slave i.
	always_comb begin
		tbl_word = '0;
		ent = '0;
		for (int i = 0; i < SLVCNT; i++) begin
			ent = soc_bus_pkg::pi1_addr_t'(FLDCNT * i);
			if (dec_offset_i == ent + soc_bus_pkg::pi1_addr_t'(soc_dev_pkg::FLD_ID))
				tbl_word = DEV_ID[i];
			if (dec_offset_i == ent + soc_bus_pkg::pi1_addr_t'(soc_dev_pkg::FLD_MAPSZ))
				tbl_word = DEV_MAPSZ[i];
			if (dec_offset_i == ent + soc_bus_pkg::pi1_addr_t'(soc_dev_pkg::FLD_USEINTR))
				tbl_word = DEV_USEINTR[i];
		end
		if (dec_offset_i == RSTREG_OFS)
			tbl_word = soc_bus_pkg::pi1_data_t'(rst_q);
	end

	// Software reset bits, cleared by the reset they request.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			rst_q <= soc_dev_pkg::RST_NONE;
		end else if (wr_en && (dec_offset_i == RSTREG_OFS)) begin
			rst_q <= soc_dev_pkg::rst_req_e'(dec_data_i[1:0]);
		end
	end

	// Old contents are captured on the same edge as the write.
	always_ff @(posedge clk100mhz_i) begin
		if (sel_hit) begin
			rd_data_o <= tbl_word;
		end
	end

	assign rst_bits_o = rst_q;

endmodule

//--- gpio_port.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module gpio_port (
	input  logic                    clk100mhz_i,
	input  logic                    sys_rst_i,
	input  logic                    dec_valid_i,
	input  soc_bus_pkg::slave_idx_e dec_slave_i,
	input  soc_bus_pkg::pi1_op_e    dec_op_i,
	input  soc_bus_pkg::pi1_addr_t  dec_offset_i,
	input  soc_bus_pkg::pi1_data_t  dec_data_i,
	input  soc_bus_pkg::pi1_sel_t   dec_sel_i,
	input  soc_dev_pkg::gpio_word_t gp_i,
	output soc_bus_pkg::pi1_data_t  rd_data_o,
	output soc_dev_pkg::gpio_word_t gp_o
);

	localparam int GPIOBYTES = `GPIOCOUNT / 8;
	localparam soc_bus_pkg::pi1_addr_t OFS_OUT = soc_bus_pkg::pi1_addr_t'(0);
	localparam soc_bus_pkg::pi1_addr_t OFS_IN = soc_bus_pkg::pi1_addr_t'(1);

	logic sel_hit;
	logic wr_en;
	soc_dev_pkg::gpio_word_t gp_q;
	soc_dev_pkg::gpio_word_t gp_meta_q;
	soc_dev_pkg::gpio_word_t gp_in_q;
	soc_bus_pkg::pi1_data_t rd_word;

	assign sel_hit = dec_valid_i && (dec_slave_i == soc_bus_pkg::SLV_GPIO);
	assign wr_en = sel_hit && ((dec_op_i == soc_bus_pkg::PI1_WR) ||
		(dec_op_i == soc_bus_pkg::PI1_RDWR));

	// Output register, one byte per select bit.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			gp_q <= '0;
		end else if (wr_en && (dec_offset_i == OFS_OUT)) begin
			for (int b = 0; b < GPIOBYTES; b++) begin
				if (dec_sel_i[b])
					gp_q[8*b +: 8] <= dec_data_i[8*b +: 8];
			end
		end
	end

	// Two flop synchronizer for the pins.
	always_ff @(posedge clk100mhz_i) begin
		gp_meta_q <= gp_i;
		gp_in_q <= gp_meta_q;
	end

	// The input register is read only, offsets 2 and 3 read 0.
	always_comb begin
		case (dec_offset_i)
		OFS_OUT: rd_word = soc_bus_pkg::pi1_data_t'(gp_q);
		OFS_IN: rd_word = soc_bus_pkg::pi1_data_t'(gp_in_q);
		default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk100mhz_i) begin
		if (sel_hit) begin
			rd_data_o <= rd_word;
		end
	end

	assign gp_o = gp_q;

endmodule

//--- pi1_decode.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module pi1_decode (
	input  logic                    clk100mhz_i,
	input  logic                    sys_rst_i,
	input  soc_bus_pkg::pi1_op_e    pi1_op_i,
	input  soc_bus_pkg::pi1_addr_t  pi1_addr_i,
	input  soc_bus_pkg::pi1_data_t  pi1_data_i,
	input  soc_bus_pkg::pi1_sel_t   pi1_sel_i,
	input  logic                    resp_done_i,
	output logic                    pi1_rdy_o,
	output logic                    dec_valid_o,
	output soc_bus_pkg::slave_idx_e dec_slave_o,
	output soc_bus_pkg::pi1_op_e    dec_op_o,
	output soc_bus_pkg::pi1_addr_t  dec_offset_o,
	output soc_bus_pkg::pi1_data_t  dec_data_o,
	output soc_bus_pkg::pi1_sel_t   dec_sel_o
);

	typedef enum logic {
		ST_IDLE,
		ST_BUSY
	} dec_state_e;

	// Base of each slave from the cumulative map sizes.
	localparam soc_bus_pkg::pi1_addr_t GPIO_BASE =
		soc_bus_pkg::pi1_addr_t'(`DEVTBL_MAPSZ);
	localparam soc_bus_pkg::pi1_addr_t INVALID_BASE =
		soc_bus_pkg::pi1_addr_t'(`DEVTBL_MAPSZ + `GPIO_MAPSZ);

	dec_state_e state_q;
	logic rdy_q;
	logic accept;
	soc_bus_pkg::slave_idx_e slave_sel;
	soc_bus_pkg::pi1_addr_t offset_sel;

	assign pi1_rdy_o = rdy_q;
	assign accept = rdy_q && (pi1_op_i != soc_bus_pkg::PI1_NOP);

	// Anything past the GPIO window lands on the invalid device.
	always_comb begin
		if (pi1_addr_i < GPIO_BASE) begin
			slave_sel = soc_bus_pkg::SLV_DEVTBL;
			offset_sel = pi1_addr_i;
		end else if (pi1_addr_i < INVALID_BASE) begin
			slave_sel = soc_bus_pkg::SLV_GPIO;
			offset_sel = pi1_addr_i - GPIO_BASE;
		end else begin
			slave_sel = soc_bus_pkg::SLV_INVALID;
			offset_sel = pi1_addr_i - INVALID_BASE;
		end
	end

	// Ready comes back one cycle after reset and after each response.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			state_q <= ST_IDLE;
			rdy_q <= 1'b0;
			dec_valid_o <= 1'b0;
		end else begin
			dec_valid_o <= accept;
			case (state_q)
			ST_IDLE: begin
				rdy_q <= !accept;
				if (accept) begin
					state_q <= ST_BUSY;
				end
			end
			ST_BUSY: begin
				if (resp_done_i) begin
					state_q <= ST_IDLE;
					rdy_q <= 1'b1;
				end
			end
			endcase
		end
	end

	// Request payload, held for the devices.
	always_ff @(posedge clk100mhz_i) begin
		if (accept) begin
			dec_slave_o <= slave_sel;
			dec_op_o <= pi1_op_i;
			dec_offset_o <= offset_sel;
			dec_data_o <= pi1_data_i;
			dec_sel_o <= pi1_sel_i;
		end
	end

	// The master keeps the bus idle until ready returns.
	assert property (@(posedge clk100mhz_i) disable iff (sys_rst_i)
		!pi1_rdy_o |-> (pi1_op_i == soc_bus_pkg::PI1_NOP));

endmodule

//--- pi1_result.sv
`timescale 1ns/1ps

module pi1_result (
	input  logic                    clk100mhz_i,
	input  logic                    sys_rst_i,
	input  logic                    dec_valid_i,
	input  soc_bus_pkg::slave_idx_e dec_slave_i,
	input  soc_bus_pkg::pi1_op_e    dec_op_i,
	input  soc_bus_pkg::pi1_data_t  devtbl_data_i,
	input  soc_bus_pkg::pi1_data_t  gpio_data_i,
	output soc_bus_pkg::pi1_data_t  pi1_data_o,
	output logic                    resp_done_o
);

	logic valid_q;
	soc_bus_pkg::slave_idx_e slave_q;
	soc_bus_pkg::pi1_op_e op_q;
	soc_bus_pkg::pi1_data_t resp_data;

	// Follows the devices by one cycle.
	always_ff @(posedge clk100mhz_i) begin
		if (sys_rst_i) begin
			valid_q <= 1'b0;
			resp_done_o <= 1'b0;
		end else begin
			valid_q <= dec_valid_i;
			resp_done_o <= valid_q;
		end
	end

	always_ff @(posedge clk100mhz_i) begin
		if (dec_valid_i) begin
			slave_q <= dec_slave_i;
			op_q <= dec_op_i;
		end
	end

	// The invalid device and plain writes answer 0.
	always_comb begin
		if (op_q == soc_bus_pkg::PI1_WR) begin
			resp_data = '0;
		end else begin
			case (slave_q)
			soc_bus_pkg::SLV_DEVTBL: resp_data = devtbl_data_i;
			soc_bus_pkg::SLV_GPIO: resp_data = gpio_data_i;
			default: resp_data = '0;
			endcase
		end
	end

	// Data holds until the next response.
	always_ff @(posedge clk100mhz_i) begin
		if (valid_q) begin
			pi1_data_o <= resp_data;
		end
	end

	// A new request only arrives once the previous one has been answered.
	assert property (@(posedge clk100mhz_i) disable iff (sys_rst_i)
		dec_valid_i |-> (!$past(dec_valid_i) && !$past(dec_valid_i, 2) &&
		!$past(dec_valid_i, 3)));

endmodule

//--- reset_seq.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module reset_seq (
	input  logic                  clk100mhz_i,
	input  logic                  rst_p,
	input  soc_dev_pkg::rst_req_e rst_bits_i,
	output logic                  sys_rst_o
);

	logic [`RST_CNTR_BITSZ-1:0] rst_cntr_q;
	logic pwroff_q;
	logic sw_reload;
	logic sw_pwroff;

	// Cold reset behaves as warm reset here.
	assign sw_reload = (rst_bits_i == soc_dev_pkg::RST_WARM) ||
		(rst_bits_i == soc_dev_pkg::RST_COLD);
	assign sw_pwroff = (rst_bits_i == soc_dev_pkg::RST_PWROFF);

	// Count down from all ones, reset is held while nonzero.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p || sw_reload) begin
			rst_cntr_q <= '1;
		end else if (|rst_cntr_q) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off is only left through the external reset.
	always_ff @(posedge clk100mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = pwroff_q || (|rst_cntr_q);

	// The device table drops its request once the reset it asked for is running.
	assert property (@(posedge clk100mhz_i)
		sys_rst_o |=> (rst_bits_i == soc_dev_pkg::RST_NONE));

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_soc_top -f verilog.f -o tb_soc_top
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/tb_soc_top 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "Test completed successfully"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- soc_bus_pkg.sv
`include "soc_params.svh"

package soc_bus_pkg;

	// PI1 operation codes.
	typedef enum logic [1:0] {
		PI1_NOP  = 2'b00,
		PI1_WR   = 2'b01,
		PI1_RD   = 2'b10,
		PI1_RDWR = 2'b11
	} pi1_op_e;

	// Word address, data and byte selects.
	typedef logic [`ADDRBITSZ-1:0] pi1_addr_t;
	typedef logic [`ARCHBITSZ-1:0] pi1_data_t;
	typedef logic [`SELBITSZ-1:0] pi1_sel_t;

	// Slave order matches the address map.
	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_INVALID = 2'd2
	} slave_idx_e;

endpackage

//--- soc_dev_pkg.sv
`include "soc_params.svh"

package soc_dev_pkg;

	// Software reset request, bit 0 and bit 1 of the reset register.
	typedef enum logic [1:0] {
		RST_NONE   = 2'b00,
		RST_PWROFF = 2'b01,
		RST_WARM   = 2'b10,
		RST_COLD   = 2'b11
	} rst_req_e;

	typedef logic [`GPIOCOUNT-1:0] gpio_word_t;

	// Three table words per slave.
	typedef enum logic [1:0] {
		FLD_ID      = 2'd0,
		FLD_MAPSZ   = 2'd1,
		FLD_USEINTR = 2'd2
	} devtbl_field_e;

endpackage

//--- soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths.
`define ARCHBITSZ 32
`define ADDRBITSZ 30
`define SELBITSZ 4

// Number of GPIO pins.
`define GPIOCOUNT 16

// Reset counter width, all ones gives 15 cycles of held reset.
`define RST_CNTR_BITSZ 4

// Map sizes in words.
// Slaves are laid out back to back from address 0 in slave index order.
`define DEVTBL_MAPSZ 16
`define GPIO_MAPSZ 4
`define INVALIDDEV_MAPSZ 1024

// Device ids as reported by the device table.
`define DEVID_DEVTBL 7
`define DEVID_GPIO 6
`define DEVID_INVALID 0

// Device table word holding the two software reset bits.
`define DEVTBL_RSTREG_IDX 15

`endif

//--- soc_testdata.txt
# name kind op addr wdata sel exp_data exp_gp, numbers in hex
# set_gpin drives wdata on gp_i; expect_reset uses exp_data 1 when sys_rst stays high
tbl_dev0_id            bus          rd   00000000 00000000 f 00000007 0000
tbl_dev0_mapsz         bus          rd   00000001 00000000 f 00000010 0000
tbl_dev0_intr          bus          rd   00000002 00000000 f 00000000 0000
tbl_dev1_id            bus          rd   00000003 00000000 f 00000006 0000
tbl_dev1_mapsz         bus          rd   00000004 00000000 f 00000004 0000
tbl_dev1_intr          bus          rd   00000005 00000000 f 00000001 0000
tbl_dev2_id            bus          rd   00000006 00000000 f 00000000 0000
tbl_dev2_mapsz         bus          rd   00000007 00000000 f 00000400 0000
tbl_dev2_intr          bus          rd   00000008 00000000 f 00000000 0000
tbl_word9              bus          rd   00000009 00000000 f 00000000 0000
tbl_word14             bus          rd   0000000e 00000000 f 00000000 0000
tbl_wr_const           bus          wr   00000003 deadbeef f 00000000 0000
tbl_dev1_id_again      bus          rd   00000003 00000000 f 00000006 0000
rst_reg_idle           bus          rd   0000000f 00000000 f 00000000 0000
gp_wr_word             bus          wr   00000010 0000a5c3 f 00000000 a5c3
gp_rd_word             bus          rd   00000010 00000000 f 0000a5c3 a5c3
gp_wr_byte0            bus          wr   00000010 12345678 1 00000000 a578
gp_wr_upper            bus          wr   00000010 9abcdef0 e 00000000 de78
gp_rd_mixed            bus          rd   00000010 00000000 f 0000de78 de78
gp_rdwr                bus          rdwr 00000010 00001111 f 0000de78 1111
gp_rd_after_rdwr       bus          rd   00000010 00000000 f 00001111 1111
gpin_drive             set_gpin     nop  00000000 00003c5a 0 00000000 1111
gpin_rd                bus          rd   00000011 00000000 f 00003c5a 1111
gpin_wr_ignored        bus          wr   00000011 ffffffff f 00000000 1111
gpin_rd_again          bus          rd   00000011 00000000 f 00003c5a 1111
gp_ofs2                bus          rd   00000012 00000000 f 00000000 1111
gp_ofs3                bus          rd   00000013 00000000 f 00000000 1111
inv_rd_first           bus          rd   00000014 00000000 f 00000000 1111
inv_wr                 bus          wr   00000100 ffffffff f 00000000 1111
inv_rdwr               bus          rdwr 000003ff 12345678 f 00000000 1111
inv_rd_top             bus          rd   3fffffff 00000000 f 00000000 1111
gp_rd_after_inv        bus          rd   00000010 00000000 f 00001111 1111
warm_rst               expect_reset wr   0000000f 00000002 f 00000000 0000
rst_reg_after_warm     bus          rd   0000000f 00000000 f 00000000 0000
gp_rd_after_warm       bus          rd   00000010 00000000 f 00000000 0000
gp_wr_before_cold      bus          wr   00000010 0000beef f 00000000 beef
cold_rst               expect_reset wr   0000000f 00000003 f 00000000 0000
gp_wr_before_off       bus          wr   00000010 0000cafe 3 00000000 cafe
pwroff                 expect_reset wr   0000000f 00000001 f 00000001 0000
tbl_dev0_id_after_off  bus          rd   00000000 00000000 f 00000007 0000
rst_reg_after_off      bus          rd   0000000f 00000000 f 00000000 0000
gp_rd_after_off        bus          rd   00000010 00000000 f 00000000 0000
gpin_rd_after_off      bus          rd   00000011 00000000 f 00003c5a 0000

//--- soc_top.sv
`timescale 1ns/1ps

module soc_top (
	input  logic                    clk100mhz_i,
	input  logic                    rst_p,
	input  soc_bus_pkg::pi1_op_e    pi1_op_i,
	input  soc_bus_pkg::pi1_addr_t  pi1_addr_i,
	input  soc_bus_pkg::pi1_data_t  pi1_data_i,
	input  soc_bus_pkg::pi1_sel_t   pi1_sel_i,
	input  soc_dev_pkg::gpio_word_t gp_i,
	output soc_bus_pkg::pi1_data_t  pi1_data_o,
	output logic                    pi1_rdy_o,
	output soc_dev_pkg::gpio_word_t gp_o,
	output logic                    sys_rst_o
);

	soc_dev_pkg::rst_req_e rst_bits;
	logic dec_valid;
	soc_bus_pkg::slave_idx_e dec_slave;
	soc_bus_pkg::pi1_op_e dec_op;
	soc_bus_pkg::pi1_addr_t dec_offset;
	soc_bus_pkg::pi1_data_t dec_data;
	soc_bus_pkg::pi1_sel_t dec_sel;
	soc_bus_pkg::pi1_data_t devtbl_data;
	soc_bus_pkg::pi1_data_t gpio_data;
	logic resp_done;

	// System reset also drives every block below.
	reset_seq reset_seq0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.rst_bits_i  (rst_bits),
		.sys_rst_o   (sys_rst_o)
	);

	pi1_decode pi1_decode0 (
		.clk100mhz_i  (clk100mhz_i),
		.sys_rst_i    (sys_rst_o),
		.pi1_op_i     (pi1_op_i),
		.pi1_addr_i   (pi1_addr_i),
		.pi1_data_i   (pi1_data_i),
		.pi1_sel_i    (pi1_sel_i),
		.resp_done_i  (resp_done),
		.pi1_rdy_o    (pi1_rdy_o),
		.dec_valid_o  (dec_valid),
		.dec_slave_o  (dec_slave),
		.dec_op_o     (dec_op),
		.dec_offset_o (dec_offset),
		.dec_data_o   (dec_data),
		.dec_sel_o    (dec_sel)
	);

	devtbl devtbl0 (
		.clk100mhz_i  (clk100mhz_i),
		.sys_rst_i    (sys_rst_o),
		.dec_valid_i  (dec_valid),
		.dec_slave_i  (dec_slave),
		.dec_op_i     (dec_op),
		.dec_offset_i (dec_offset),
		.dec_data_i   (dec_data),
		.rd_data_o    (devtbl_data),
		.rst_bits_o   (rst_bits)
	);

	gpio_port gpio_port0 (
		.clk100mhz_i  (clk100mhz_i),
		.sys_rst_i    (sys_rst_o),
		.dec_valid_i  (dec_valid),
		.dec_slave_i  (dec_slave),
		.dec_op_i     (dec_op),
		.dec_offset_i (dec_offset),
		.dec_data_i   (dec_data),
		.dec_sel_i    (dec_sel),
		.gp_i         (gp_i),
		.rd_data_o    (gpio_data),
		.gp_o         (gp_o)
	);

	pi1_result pi1_result0 (
		.clk100mhz_i   (clk100mhz_i),
		.sys_rst_i     (sys_rst_o),
		.dec_valid_i   (dec_valid),
		.dec_slave_i   (dec_slave),
		.dec_op_i      (dec_op),
		.devtbl_data_i (devtbl_data),
		.gpio_data_i   (gpio_data),
		.pi1_data_o    (pi1_data_o),
		.resp_done_o   (resp_done)
	);

endmodule

//--- tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_params.svh"

module tb_soc_top;

	typedef logic [8*32-1:0] label_t;
	typedef logic [8*128-1:0] line_t;

	localparam int RST_CYCLES = 16;
	localparam int BUS_LATENCY = 3;
	// Full reset counter span with some margin.
	localparam int RST_SPAN = (1 << `RST_CNTR_BITSZ) + 4;

	logic clk100mhz_i = 1'b0;
	logic rst_p;
	soc_bus_pkg::pi1_op_e pi1_op_i;
	soc_bus_pkg::pi1_addr_t pi1_addr_i;
	soc_bus_pkg::pi1_data_t pi1_data_i;
	soc_bus_pkg::pi1_sel_t pi1_sel_i;
	soc_dev_pkg::gpio_word_t gp_i;
	soc_bus_pkg::pi1_data_t pi1_data_o;
	logic pi1_rdy_o;
	soc_dev_pkg::gpio_word_t gp_o;
	logic sys_rst_o;

	logic loaded = 1'b0;
	int test_cnt = 0;

	// One entry per data line.
	label_t name_q[$];
	label_t kind_q[$];
	soc_bus_pkg::pi1_op_e op_q[$];
	soc_bus_pkg::pi1_addr_t addr_q[$];
	soc_bus_pkg::pi1_data_t wdata_q[$];
	soc_bus_pkg::pi1_sel_t sel_q[$];
	soc_bus_pkg::pi1_data_t exp_data_q[$];
	soc_dev_pkg::gpio_word_t exp_gp_q[$];

	soc_top dut0 (
		.clk100mhz_i (clk100mhz_i),
		.rst_p       (rst_p),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_data_i  (pi1_data_i),
		.pi1_sel_i   (pi1_sel_i),
		.gp_i        (gp_i),
		.pi1_data_o  (pi1_data_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.gp_o        (gp_o),
		.sys_rst_o   (sys_rst_o)
	);

	always #5 clk100mhz_i = ~clk100mhz_i;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input label_t name, input string what,
		input soc_bus_pkg::pi1_data_t exp, input soc_bus_pkg::pi1_data_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %0s %s expected %h actual %h", name, what, exp, act));
	endtask

	task automatic check_gpio(input label_t name, input string what,
		input soc_dev_pkg::gpio_word_t exp, input soc_dev_pkg::gpio_word_t act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %0s %s expected %h actual %h", name, what, exp, act));
	endtask

	task automatic check_rst(input label_t name, input string what,
		input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("MISMATCH %0s %s expected %b actual %b", name, what, exp, act));
	endtask

	task automatic compare_latency(input label_t name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("MISMATCH %0s latency expected %0d actual %0d", name, exp, act));
	endtask

	// First visible character of a line, 0 for an empty one.
	function automatic logic [7:0] lead_char(input line_t line);
		logic [7:0] c;
		lead_char = 8'h00;
		for (int i = $bits(line_t) / 8 - 1; i >= 0; i--) begin
			c = line[8*i +: 8];
			if (lead_char == 8'h00 && c != 8'h00 && c != " " && c != "\t")
				lead_char = c;
		end
	endfunction

	task automatic load_testdata();
		int fd;
		int code;
		line_t line;
		logic [7:0] lead;
		label_t name;
		label_t kind;
		label_t op_tok;
		soc_bus_pkg::pi1_op_e op;
		soc_bus_pkg::pi1_addr_t addr;
		soc_bus_pkg::pi1_data_t wdata;
		soc_bus_pkg::pi1_sel_t sel;
		soc_bus_pkg::pi1_data_t exp_data;
		soc_dev_pkg::gpio_word_t exp_gp;
		fd = $fopen("soc_testdata.txt", "r");
		if (fd == 0)
			fail_run("cannot open soc_testdata.txt");
		while (!$feof(fd)) begin
			line = '0;
			code = $fgets(line, fd);
			lead = lead_char(line);
			if (code > 0 && lead != "#" && lead != 8'h00 && lead != 8'h0a && lead != 8'h0d) begin
				code = $sscanf(line, "%s %s %s %h %h %h %h %h", name, kind, op_tok,
					addr, wdata, sel, exp_data, exp_gp);
				if (code != 8)
					fail_run($sformatf("malformed test line: %0s", line));
				op = soc_bus_pkg::PI1_NOP;
				if (op_tok == "rd")
					op = soc_bus_pkg::PI1_RD;
				else if (op_tok == "wr")
					op = soc_bus_pkg::PI1_WR;
				else if (op_tok == "rdwr")
					op = soc_bus_pkg::PI1_RDWR;
				else if (op_tok != "nop")
					fail_run($sformatf("unknown operation %0s in %0s", op_tok, name));
				if (kind != "bus" && kind != "set_gpin" && kind != "expect_reset")
					fail_run($sformatf("unknown kind %0s in %0s", kind, name));
				name_q.push_back(name);
				kind_q.push_back(kind);
				op_q.push_back(op);
				addr_q.push_back(addr);
				wdata_q.push_back(wdata);
				sel_q.push_back(sel);
				exp_data_q.push_back(exp_data);
				exp_gp_q.push_back(exp_gp);
			end
		end
		$fclose(fd);
		test_cnt = name_q.size();
		if (test_cnt == 0)
			fail_run("no test lines found in soc_testdata.txt");
	endtask

	task automatic apply_reset();
		rst_p = 1'b1;
		repeat (RST_CYCLES) @(negedge clk100mhz_i);
		rst_p = 1'b0;
	endtask

	task automatic wait_ready(input label_t name, input int limit);
		int n;
		n = 0;
		while (pi1_rdy_o !== 1'b1) begin
			if (n == limit)
				fail_run($sformatf("pi1_rdy_o stayed low for %0d cycles in %0s", limit, name));
			@(negedge clk100mhz_i);
			n++;
		end
	endtask

	// Drives one request and returns on the falling edge after acceptance.
	task automatic issue(input int idx);
		wait_ready(name_q[idx], 2 * RST_SPAN);
		pi1_op_i = op_q[idx];
		pi1_addr_i = addr_q[idx];
		pi1_data_i = wdata_q[idx];
		pi1_sel_i = sel_q[idx];
		@(posedge clk100mhz_i);
		@(negedge clk100mhz_i);
		pi1_op_i = soc_bus_pkg::PI1_NOP;
	endtask

	task automatic run_bus(input int idx);
		int edges;
		issue(idx);
		edges = 0;
		while (pi1_rdy_o !== 1'b1 && edges <= BUS_LATENCY) begin
			@(posedge clk100mhz_i);
			edges++;
			@(negedge clk100mhz_i);
		end
		compare_latency(name_q[idx], BUS_LATENCY, edges);
		check_data(name_q[idx], "data", exp_data_q[idx], pi1_data_o);
		check_gpio(name_q[idx], "gp_o", exp_gp_q[idx], gp_o);
	endtask

	task automatic apply_gpin(input int idx);
		soc_bus_pkg::pi1_data_t pins;
		pins = wdata_q[idx];
		gp_i = pins[`GPIOCOUNT-1:0];
		// Let the pins pass the two flop synchronizer.
		repeat (3) @(negedge clk100mhz_i);
		check_gpio(name_q[idx], "gp_o", exp_gp_q[idx], gp_o);
	endtask

	task automatic expect_reset_seq(input int idx);
		int n;
		soc_bus_pkg::pi1_data_t held;
		held = exp_data_q[idx];
		issue(idx);
		n = 0;
		while (sys_rst_o !== 1'b1 && n < BUS_LATENCY) begin
			@(negedge clk100mhz_i);
			n++;
		end
		check_rst(name_q[idx], "sys_rst_o", 1'b1, sys_rst_o);
		@(negedge clk100mhz_i);
		check_gpio(name_q[idx], "gp_o in reset", exp_gp_q[idx], gp_o);
		check_rst(name_q[idx], "pi1_rdy_o in reset", 1'b0, pi1_rdy_o);
		repeat (RST_SPAN) @(negedge clk100mhz_i);
		check_rst(name_q[idx], "sys_rst_o held", held[0], sys_rst_o);
		// Power-off only ends with the external reset.
		if (sys_rst_o)
			apply_reset();
		wait_ready(name_q[idx], 2 * RST_SPAN);
		check_rst(name_q[idx], "sys_rst_o released", 1'b0, sys_rst_o);
		check_gpio(name_q[idx], "gp_o after reset", exp_gp_q[idx], gp_o);
	endtask

	initial begin
		rst_p = 1'b1;
		pi1_op_i = soc_bus_pkg::PI1_NOP;
		pi1_addr_i = '0;
		pi1_data_i = '0;
		pi1_sel_i = '0;
		gp_i = '0;
		load_testdata();
		loaded = 1'b1;
		apply_reset();
		wait_ready("initial reset", 2 * RST_SPAN);
		for (int i = 0; i < test_cnt; i++) begin
			if (kind_q[i] == "bus")
				run_bus(i);
			else if (kind_q[i] == "set_gpin")
				apply_gpin(i);
			else
				expect_reset_seq(i);
		end
		$display("Test completed successfully");
		$finish;
	end

	// Budget grows with the number of data lines.
	initial begin
		wait (loaded);
		repeat (40 * test_cnt + 100) @(posedge clk100mhz_i);
		fail_run($sformatf("watchdog expired after %0d cycles", 40 * test_cnt + 100));
	end

endmodule

//--- verilog.f
+incdir+.
soc_bus_pkg.sv
soc_dev_pkg.sv
reset_seq.sv
pi1_decode.sv
devtbl.sv
gpio_port.sv
pi1_result.sv
soc_top.sv
tb_soc_top.sv
